// ==== istream.f ====
rtl/istream_pkg.sv
rtl/istream_lsb_pick.sv
rtl/istream_way_select.sv
rtl/istream_set_buffer.sv
rtl/istream.sv
tb/istream_clk_gen.sv
tb/istream_sva.sv
tb/istream_tb.sv

// ==== Makefile ====
# Verilator build and run for the instruction stream buffer

TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = istream_tb
FILELIST = istream.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/istream_tb.sv ====
// --------------------
// random fetch blocks against a queue model of the instruction stream
// an all-invalid block never follows an unpaired uncompressed start
// --------------------

`default_nettype none

module istream_tb
    import istream_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_CYCLES  = 300;
    localparam int DRAIN_LIMIT    = 200;
    localparam int BUDGET_RESET   = 20 + DRAIN_LIMIT;
    localparam int BUDGET_RANDOM  = RANDOM_CYCLES + DRAIN_LIMIT;
    localparam int BUDGET_FILL    = 50 + DRAIN_LIMIT;
    localparam int BUDGET_RESTART = 20 + DRAIN_LIMIT;
    localparam int WATCHDOG_NS    =
        (BUDGET_RESET + BUDGET_RANDOM + BUDGET_FILL + BUDGET_RESTART) * 10 * 2;

    logic                         CLK;
    logic                         nRST;
    logic                         valid_senq;
    chunk_mask_t                  chunk_valid_senq;
    chunk_t [CHUNKS_PER_SET-1:0]  chunks_senq;
    pc_t                          after_pc_senq;
    logic                         stall_senq;
    logic                         valid_sdeq;
    way_mask_t                    valid_by_way;
    way_mask_t                    uncompressed_by_way;
    chunk_t [NUM_WAYS-1:0]        lower_chunk_by_way;
    chunk_t [NUM_WAYS-1:0]        upper_chunk_by_way;
    pc_t [NUM_WAYS-1:0]           pc_by_way;
    logic                         stall_sdeq;
    logic                         restart;
    pc_t                          restart_pc;

    // model state, entries are {uncompressed, lower, upper, pc}
    logic [64:0] exp_q [$];
    logic        pend;
    chunk_t      pend_chunk;
    pc_t         pend_pc;
    block_pc_t   blk;
    logic        idle_chk;
    logic        restart_chk;
    pc_t         restart_exp;
    int          errors;
    int          tests_run;
    int          accept_cnt;
    logic [31:0] rng_state;

    istream_clk_gen u_clk_gen (
        .CLK  (CLK),
        .nRST (nRST)
    );

    istream istream_i (
        .CLK                 (CLK),
        .nRST                (nRST),
        .valid_senq          (valid_senq),
        .chunk_valid_senq    (chunk_valid_senq),
        .chunks_senq         (chunks_senq),
        .after_pc_senq       (after_pc_senq),
        .stall_senq          (stall_senq),
        .valid_sdeq          (valid_sdeq),
        .valid_by_way        (valid_by_way),
        .uncompressed_by_way (uncompressed_by_way),
        .lower_chunk_by_way  (lower_chunk_by_way),
        .upper_chunk_by_way  (upper_chunk_by_way),
        .pc_by_way           (pc_by_way),
        .stall_sdeq          (stall_sdeq),
        .restart             (restart),
        .restart_pc          (restart_pc)
    );

    bind istream istream_sva u_sva (
        .CLK                 (CLK),
        .nRST                (nRST),
        .valid_senq          (valid_senq),
        .stall_senq          (stall_senq),
        .stall_sdeq          (stall_sdeq),
        .restart             (restart),
        .valid_sdeq          (valid_sdeq),
        .valid_by_way        (valid_by_way),
        .uncompressed_by_way (uncompressed_by_way),
        .lower_chunk_by_way  (lower_chunk_by_way),
        .upper_chunk_by_way  (upper_chunk_by_way),
        .pc_by_way           (pc_by_way)
    );

    // high half of the state, low bits of an lcg repeat quickly
    function logic [15:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[31:16];
    endfunction

    task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH time=%0t %s got=%h expected=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    // --------------------
    // reference model
    // --------------------
    task model_block(input chunk_mask_t m, input chunk_t [CHUNKS_PER_SET-1:0] c,
                     input pc_t after);
        pc_t pc;
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            if (m[i]) begin
                pc = {blk, 3'(i), 1'b0};
                if (pend) begin
                    exp_q.push_back({1'b1, pend_chunk, c[i], pend_pc});
                    pend = 1'b0;
                end else if (c[i][1:0] == 2'b11) begin
                    pend       = 1'b1;
                    pend_chunk = c[i];
                    pend_pc    = pc;
                end else begin
                    exp_q.push_back({1'b0, c[i], 16'h0000, pc});
                end
            end
        end
        blk = after[31:4];
    endtask

    task check_ways();
        logic [64:0] e;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_by_way[w]) begin
                if (exp_q.size() == 0) begin
                    $display("way %0d issued an unexpected instruction at %0t", w, $time);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    check_value($sformatf("uncompressed_by_way[%0d]", w),
                                32'(uncompressed_by_way[w]), 32'(e[64]));
                    check_value($sformatf("lower_chunk_by_way[%0d]", w),
                                32'(lower_chunk_by_way[w]), 32'(e[63:48]));
                    // upper chunk only means something for uncompressed
                    if (e[64]) begin
                        check_value($sformatf("upper_chunk_by_way[%0d]", w),
                                    32'(upper_chunk_by_way[w]), 32'(e[47:32]));
                    end
                    check_value($sformatf("pc_by_way[%0d]", w), pc_by_way[w], e[31:0]);
                end
            end
        end
    endtask

    // inputs change 1 ns after the edge, so pre-edge values are read here
    always @(posedge CLK) begin
        if (!nRST) begin
            exp_q.delete();
            pend     = 1'b0;
            blk      = INIT_PC[31:4];
            idle_chk = 1'b1;
        end else begin
            if (idle_chk) begin
                assert (!valid_sdeq && !stall_senq) else begin
                    $display("dequeue or stall active before any block at %0t", $time);
                    errors++;
                end
            end
            if (restart_chk && valid_sdeq) begin
                check_value("pc_by_way[0]", pc_by_way[0], restart_exp);
                restart_chk = 1'b0;
            end
            if (restart) begin
                exp_q.delete();
                pend     = 1'b0;
                blk      = restart_pc[31:4];
                idle_chk = 1'b1;
            end else begin
                if (!stall_sdeq) begin
                    check_ways();
                end
                if (valid_senq && !stall_senq) begin
                    model_block(chunk_valid_senq, chunks_senq, after_pc_senq);
                    accept_cnt++;
                    idle_chk = 1'b0;
                end
            end
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------
    task step();
        @(posedge CLK);
        #1;
    endtask

    // about half of the start chunks are uncompressed
    task gen_block(input logic force_full);
        logic [15:0] r;
        chunk_mask_t m;
        for (int i = 0; i < CHUNKS_PER_SET; i++) begin
            r = lcg_next();
            chunks_senq[i] = {r[15:2], r[0] ? 2'b11 : {1'b0, r[1]}};
        end
        r = lcg_next();
        if (force_full || r[2:0] == 3'd1) begin
            m = '1;
        end else if (r[2:0] == 3'd0) begin
            m = '0;
        end else begin
            m = chunk_mask_t'(lcg_next());
        end
        // an empty set after an open start would never be released
        if (pend && m == '0) begin
            m = 8'h01;
        end
        chunk_valid_senq = m;
        if (r[7:4] == 4'd0) begin
            after_pc_senq = {lcg_next(), lcg_next() & 16'hfff0};
        end else begin
            after_pc_senq = {blk + 28'd1, 4'h0};
        end
    endtask

    task drain();
        int n;
        valid_senq = 1'b0;
        stall_sdeq = 1'b0;
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            step();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("drain timed out with %0d instructions left", exp_q.size());
            errors++;
        end
    endtask

    task report(input string name, input int err0);
        $display("test %s: %s (%0d errors)", name,
                 (errors == err0) ? "ok" : "failed", errors - err0);
        tests_run++;
    endtask

    // --------------------
    // tests
    // --------------------
    initial begin
        int err0;
        int n;
        logic [15:0] r;

        rng_state        = 32'd34394;
        errors           = 0;
        tests_run        = 0;
        accept_cnt       = 0;
        restart_chk      = 1'b0;
        valid_senq       = 1'b0;
        chunk_valid_senq = '0;
        chunks_senq      = '0;
        after_pc_senq    = '0;
        stall_sdeq       = 1'b0;
        restart          = 1'b0;
        restart_pc       = '0;

        wait (nRST);
        step();

        err0 = errors;
        repeat (5) step();
        gen_block(1'b1);
        valid_senq = 1'b1;
        step();
        drain();
        report("reset_idle", err0);

        err0 = errors;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            r = lcg_next();
            valid_senq = r[1:0] != 2'd0;
            stall_sdeq = r[3:2] == 2'd0;
            gen_block(1'b0);
            step();
        end
        drain();
        report("random_traffic", err0);

        err0 = errors;
        restart    = 1'b1;
        restart_pc = INIT_PC + 32'h0000_1000;
        step();
        restart    = 1'b0;
        stall_sdeq = 1'b1;
        accept_cnt = 0;
        valid_senq = 1'b1;
        n = 0;
        while (!stall_senq && n < 40) begin
            gen_block(1'b0);
            step();
            n++;
        end
        // keep offering blocks while full and stalled
        repeat (3) begin
            gen_block(1'b0);
            step();
        end
        valid_senq = 1'b0;
        check_value("accepted blocks", accept_cnt, BUFFER_SETS);
        check_value("stall_senq", 32'(stall_senq), 32'd1);
        drain();
        report("fill_and_stall", err0);

        err0 = errors;
        stall_sdeq = 1'b1;
        valid_senq = 1'b1;
        repeat (4) begin
            gen_block(1'b0);
            step();
        end
        valid_senq  = 1'b0;
        restart     = 1'b1;
        restart_pc  = {lcg_next(), lcg_next()};
        restart_exp = {restart_pc[31:4], 4'h0};
        step();
        restart     = 1'b0;
        restart_chk = 1'b1;
        repeat (3) step();
        gen_block(1'b1);
        valid_senq = 1'b1;
        step();
        drain();
        if (restart_chk) begin
            $display("no instruction was issued after the restart");
            errors++;
            restart_chk = 1'b0;
        end
        report("restart", err0);

        $display("tests run %0d, errors %0d", tests_run, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/istream_sva.sv ====
// --------------------
// protocol checks on the istream ports
// hold check skips cycles where a block is taken into the window
// --------------------

`default_nettype none

module istream_sva
    import istream_pkg::*;
(
    input logic                   CLK,
    input logic                   nRST,
    input logic                   valid_senq,
    input logic                   stall_senq,
    input logic                   stall_sdeq,
    input logic                   restart,
    input logic                   valid_sdeq,
    input way_mask_t              valid_by_way,
    input way_mask_t              uncompressed_by_way,
    input chunk_t [NUM_WAYS-1:0]  lower_chunk_by_way,
    input chunk_t [NUM_WAYS-1:0]  upper_chunk_by_way,
    input pc_t [NUM_WAYS-1:0]     pc_by_way
);

    timeunit 1ns;
    timeprecision 100ps;

    // ways fill from way 0 upward
    a_contiguous: assert property (@(posedge CLK) disable iff (!nRST)
        valid_by_way inside {4'b0000, 4'b0001, 4'b0011, 4'b0111, 4'b1111})
        else $error("valid_by_way has a gap");

    a_way0: assert property (@(posedge CLK) disable iff (!nRST)
        valid_sdeq == valid_by_way[0])
        else $error("valid_sdeq differs from way 0 valid");

    // full buffer with dequeue stalled takes nothing and frees nothing
    a_full_hold: assert property (@(posedge CLK) disable iff (!nRST)
        stall_senq && stall_sdeq && !restart |=> stall_senq)
        else $error("buffer left the full state under dequeue stall");

    a_deq_hold: assert property (@(posedge CLK) disable iff (!nRST)
        stall_sdeq && !restart && !(valid_senq && !stall_senq) |=>
            $stable(valid_by_way) && $stable(uncompressed_by_way) &&
            $stable(lower_chunk_by_way) && $stable(upper_chunk_by_way) &&
            $stable(pc_by_way))
        else $error("dequeue outputs changed under stall");

endmodule

`default_nettype wire

// ==== tb/istream_clk_gen.sv ====
// --------------------
// 10 ns clock, reset held low for the first 10 rising edges
// --------------------

`default_nettype none

module istream_clk_gen (
    output logic CLK,
    output logic nRST
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // release just after an edge so it never meets the clock
    initial begin
        nRST = 1'b0;
        repeat (10) @(posedge CLK);
        #1 nRST = 1'b1;
    end

endmodule

`default_nettype wire

// ==== rtl/istream.sv ====
// --------------------
// instruction stream buffer, up to four instructions per cycle
// dequeue outputs are combinational from the stored sets
// --------------------

`default_nettype none

module istream
    import istream_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,

    // enqueue side
    input  logic                            valid_senq,
    input  chunk_mask_t                     chunk_valid_senq,
    input  chunk_t [CHUNKS_PER_SET-1:0]     chunks_senq,
    input  pc_t                             after_pc_senq,
    output logic                            stall_senq,

    // dequeue side
    output logic                            valid_sdeq,
    output way_mask_t                       valid_by_way,
    output way_mask_t                       uncompressed_by_way,
    output chunk_t [NUM_WAYS-1:0]           lower_chunk_by_way,
    output chunk_t [NUM_WAYS-1:0]           upper_chunk_by_way,
    output pc_t [NUM_WAYS-1:0]              pc_by_way,
    input  logic                            stall_sdeq,

    input  logic                            restart,
    input  pc_t                             restart_pc
);

    window_mask_t                 win_valid;
    chunk_t [WINDOW_CHUNKS-1:0]   win_chunks;
    block_pc_t                    base_pc0;
    block_pc_t                    base_pc1;
    window_mask_t                 ack_vec;

    istream_set_buffer u_set_buffer (
        .CLK              (CLK),
        .nRST             (nRST),
        .valid_senq       (valid_senq),
        .chunk_valid_senq (chunk_valid_senq),
        .chunks_senq      (chunks_senq),
        .after_pc_senq    (after_pc_senq),
        .stall_senq       (stall_senq),
        .win_valid        (win_valid),
        .win_chunks       (win_chunks),
        .base_pc0         (base_pc0),
        .base_pc1         (base_pc1),
        .ack_vec          (ack_vec),
        .stall_sdeq       (stall_sdeq),
        .restart          (restart),
        .restart_pc       (restart_pc)
    );

    istream_way_select u_way_select (
        .win_valid           (win_valid),
        .win_chunks          (win_chunks),
        .base_pc0            (base_pc0),
        .base_pc1            (base_pc1),
        .ack_vec             (ack_vec),
        .valid_by_way        (valid_by_way),
        .uncompressed_by_way (uncompressed_by_way),
        .lower_chunk_by_way  (lower_chunk_by_way),
        .upper_chunk_by_way  (upper_chunk_by_way),
        .pc_by_way           (pc_by_way)
    );

    // ways are contiguous, so way 0 stands for the whole group
    assign valid_sdeq = valid_by_way[0];

endmodule

`default_nettype wire

// ==== rtl/istream_set_buffer.sv ====
// --------------------
// circular array of fetch blocks with a two-set dequeue window
// stall_senq is high exactly when all sets are occupied
// restart drops every stored set and reloads the block pc
// --------------------

`default_nettype none

module istream_set_buffer
    import istream_pkg::*;
(
    input  logic                            CLK,
    input  logic                            nRST,

    // enqueue from fetch
    input  logic                            valid_senq,
    input  chunk_mask_t                     chunk_valid_senq,
    input  chunk_t [CHUNKS_PER_SET-1:0]     chunks_senq,
    input  pc_t                             after_pc_senq,
    output logic                            stall_senq,

    // window towards way selection
    output window_mask_t                    win_valid,
    output chunk_t [WINDOW_CHUNKS-1:0]      win_chunks,
    output block_pc_t                       base_pc0,
    output block_pc_t                       base_pc1,
    input  window_mask_t                    ack_vec,
    input  logic                            stall_sdeq,

    input  logic                            restart,
    input  pc_t                             restart_pc
);

    // --------------------
    // storage
    // --------------------
    chunk_mask_t                  set_valid  [BUFFER_SETS];
    chunk_t [CHUNKS_PER_SET-1:0]  set_chunks [BUFFER_SETS];
    block_pc_t                    set_after  [BUFFER_SETS];

    set_ptr_t   enq_ptr;
    set_ptr_t   deq_ptr;
    set_ptr_t   deq1_ptr;
    set_ptr_t   occupancy;

    logic [SET_IDX_W-1:0] enq_idx;
    logic [SET_IDX_W-1:0] deq0_idx;
    logic [SET_IDX_W-1:0] deq1_idx;

    logic        occ0;
    logic        occ1;
    logic        full;
    logic        enq_fire;
    logic        deq_fire;
    logic        done0;
    logic        done1;
    logic [1:0]  release_cnt;
    chunk_mask_t valid0;
    chunk_mask_t valid1;

    // --------------------
    // pointers and occupancy
    // --------------------
    assign deq1_ptr  = deq_ptr + set_ptr_t'(1);
    assign enq_idx   = enq_ptr[SET_IDX_W-1:0];
    assign deq0_idx  = deq_ptr[SET_IDX_W-1:0];
    assign deq1_idx  = deq1_ptr[SET_IDX_W-1:0];

    // wrap bit makes the difference range 0..BUFFER_SETS
    assign occupancy = enq_ptr - deq_ptr;
    assign occ0      = occupancy != '0;
    assign occ1      = occupancy > set_ptr_t'(1);
    assign full      = occupancy == set_ptr_t'(BUFFER_SETS);

    assign stall_senq = full;
    assign enq_fire   = valid_senq & ~full & ~restart;
    assign deq_fire   = ~stall_sdeq & ~restart;

    // --------------------
    // window alignment
    // --------------------
    // unoccupied halves show no valid chunks
    assign valid0 = occ0 ? set_valid[deq0_idx] : '0;
    assign valid1 = occ1 ? set_valid[deq1_idx] : '0;

    assign win_valid  = {valid1, valid0};
    assign win_chunks = {set_chunks[deq1_idx], set_chunks[deq0_idx]};
    assign base_pc1   = set_after[deq0_idx];

    // set is done when every remaining chunk is acked now
    assign done0 = occ0 & ~|(valid0 & ~ack_vec[CHUNKS_PER_SET-1:0]);
    assign done1 = occ1 & ~|(valid1 & ~ack_vec[WINDOW_CHUNKS-1:CHUNKS_PER_SET]);

    // sets leave strictly in order
    assign release_cnt = (done0 & done1) ? 2'd2 : (done0 ? 2'd1 : 2'd0);

    // --------------------
    // set array
    // --------------------
    always_ff @(posedge CLK) begin
        if (enq_fire) begin
            set_valid[enq_idx]  <= chunk_valid_senq;
            set_chunks[enq_idx] <= chunks_senq;
            set_after[enq_idx]  <= after_pc_senq[31:4];
        end
        // retire acked chunks, the enqueue slot is never in the window
        if (deq_fire) begin
            for (int i = 0; i < CHUNKS_PER_SET; i++) begin
                if (ack_vec[i]) begin
                    set_valid[deq0_idx][i] <= 1'b0;
                end
                if (ack_vec[i + CHUNKS_PER_SET]) begin
                    set_valid[deq1_idx][i] <= 1'b0;
                end
            end
        end
    end

    // --------------------
    // control registers
    // --------------------
    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            enq_ptr  <= '0;
            deq_ptr  <= '0;
            base_pc0 <= INIT_PC[31:4];
        end else if (restart) begin
            enq_ptr  <= '0;
            deq_ptr  <= '0;
            base_pc0 <= restart_pc[31:4];
        end else begin
            if (enq_fire) begin
                enq_ptr <= enq_ptr + set_ptr_t'(1);
            end
            if (deq_fire) begin
                deq_ptr <= deq_ptr + set_ptr_t'(release_cnt);
                // next block address comes from the last released set
                if (release_cnt == 2'd2) begin
                    base_pc0 <= set_after[deq1_idx];
                end else if (release_cnt == 2'd1) begin
                    base_pc0 <= set_after[deq0_idx];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/istream_way_select.sv ====
// --------------------
// splits the two-set window into up to four instructions in program order
// an uncompressed start chunk needs a later valid chunk in the window
// pc is always the address of the lower chunk
// --------------------

`default_nettype none

module istream_way_select
    import istream_pkg::*;
(
    input  window_mask_t                   win_valid,
    input  chunk_t [WINDOW_CHUNKS-1:0]     win_chunks,
    input  block_pc_t                      base_pc0,
    input  block_pc_t                      base_pc1,

    output window_mask_t                   ack_vec,
    output way_mask_t                      valid_by_way,
    output way_mask_t                      uncompressed_by_way,
    output chunk_t [NUM_WAYS-1:0]          lower_chunk_by_way,
    output chunk_t [NUM_WAYS-1:0]          upper_chunk_by_way,
    output pc_t [NUM_WAYS-1:0]             pc_by_way
);

    // --------------------
    // picker chain
    // --------------------
    window_mask_t lower_req   [NUM_WAYS];
    window_mask_t lower_above [NUM_WAYS];
    window_mask_t upper_above [NUM_WAYS];
    win_idx_t     lower_idx   [NUM_WAYS];
    win_idx_t     upper_idx   [NUM_WAYS];
    logic         lower_found [NUM_WAYS];
    logic         upper_found [NUM_WAYS];
    logic         lower_unc   [NUM_WAYS];

    // way 0 starts from the whole window
    assign lower_req[0] = win_valid;

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way

        istream_lsb_pick u_lower (
            .req        (lower_req[w]),
            .found      (lower_found[w]),
            .idx        (lower_idx[w]),
            .above_mask (lower_above[w])
        );

        // upper chunk is the next valid chunk after the lower one
        istream_lsb_pick u_upper (
            .req        (lower_above[w]),
            .found      (upper_found[w]),
            .idx        (upper_idx[w]),
            .above_mask (upper_above[w])
        );

        assign lower_unc[w] = win_chunks[lower_idx[w]][1:0] == 2'b11;

        // an unpaired uncompressed chunk leaves upper_above empty,
        // so every later way sees no requests
        if (w < NUM_WAYS - 1) begin : g_next
            assign lower_req[w+1] = lower_unc[w] ? upper_above[w] : lower_above[w];
        end
    end

    // --------------------
    // way outputs and ack
    // --------------------
    always_comb begin
        block_pc_t blk;

        ack_vec = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            valid_by_way[w]        = lower_found[w] & (~lower_unc[w] | upper_found[w]);
            uncompressed_by_way[w] = lower_unc[w];
            lower_chunk_by_way[w]  = win_chunks[lower_idx[w]];
            upper_chunk_by_way[w]  = win_chunks[upper_idx[w]];

            if (valid_by_way[w]) begin
                ack_vec[lower_idx[w]] = 1'b1;
                if (lower_unc[w]) begin
                    ack_vec[upper_idx[w]] = 1'b1;
                end
            end

            // top index bit selects the second set of the window
            blk = lower_idx[w][WIN_IDX_W-1] ? base_pc1 : base_pc0;
            pc_by_way[w] = {blk, lower_idx[w][WIN_IDX_W-2:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/istream_lsb_pick.sv ====
// --------------------
// lowest-set-bit picker over the dequeue window
// idx is zero and above_mask is empty when nothing is requested
// --------------------

`default_nettype none

module istream_lsb_pick
    import istream_pkg::*;
(
    input  window_mask_t req,
    output logic         found,
    output win_idx_t     idx,
    output window_mask_t above_mask
);

    // scan upward from chunk 0
    // bits after the first hit form the cold mask
    always_comb begin
        found      = 1'b0;
        idx        = '0;
        above_mask = '0;
        for (int i = 0; i < WINDOW_CHUNKS; i++) begin
            if (found) begin
                above_mask[i] = req[i];
            end else if (req[i]) begin
                found = 1'b1;
                idx   = win_idx_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/istream_pkg.sv ====
// --------------------
// widths and counts for the instruction stream buffer
// block format is fixed at eight 2-byte chunks per 16-byte fetch block
// --------------------

`default_nettype none

package istream_pkg;

    // --------------------
    // counts
    // --------------------
    localparam int CHUNKS_PER_SET = 8;
    localparam int WINDOW_CHUNKS  = 2 * CHUNKS_PER_SET;
    localparam int NUM_WAYS       = 4;
    localparam int BUFFER_SETS    = 8;
    localparam int SET_IDX_W      = 3;
    localparam int WIN_IDX_W      = 4;

    // --------------------
    // vector types
    // --------------------
    typedef logic [15:0] chunk_t;
    typedef logic [31:0] pc_t;
    // pc without the byte offset inside a block
    typedef logic [27:0] block_pc_t;

    typedef logic [CHUNKS_PER_SET-1:0] chunk_mask_t;
    typedef logic [WINDOW_CHUNKS-1:0]  window_mask_t;
    typedef logic [NUM_WAYS-1:0]       way_mask_t;
    typedef logic [WIN_IDX_W-1:0]      win_idx_t;

    // set index with wrap bit on top
    typedef logic [SET_IDX_W:0] set_ptr_t;

    localparam pc_t INIT_PC = 32'h8000_0000;

endpackage

`default_nettype wire
